// File: hw/engine_pkg.sv
package engine_pkg;

	// lane geometry
	localparam int LANES   = 4;
	localparam int WORD_W  = 16;
	localparam int ACC_W   = 32;

	// operand memory
	localparam int ADDR_W  = 6;
	localparam int DEPTH   = 1 << ADDR_W; // 64 words per bank

	// window length is 2**klog2
	localparam int KLOG2_W = 2;
	localparam int CNT_W   = 1 << KLOG2_W; // wide enough for the longest window

	typedef logic signed [WORD_W-1:0] word_t;
	typedef word_t [LANES-1:0]        lane_vec_t; // one memory word
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic [ADDR_W-1:0]        addr_t;
	typedef logic [CNT_W-1:0]         cnt_t;

	typedef enum logic {
		POOL_MAX = 1'b0,
		POOL_AVG = 1'b1
	} pool_op_t;

	// upper clamp of the conv output
	localparam word_t SAT_MAX = word_t'(32767);

endpackage

// File: hw/operand_mem.sv
`timescale 1ns/100ps

module operand_mem import engine_pkg::*; (
	input  logic      clk,
	// load port from testbench
	input  logic      i_wr_en,
	input  logic      i_wr_sel,
	input  addr_t     i_wr_addr,
	input  lane_vec_t i_wr_data,
	// read port from arbiter
	input  logic      i_rd_en,
	input  addr_t     i_rd_daddr,
	input  addr_t     i_rd_waddr,
	output lane_vec_t o_rd_data,
	output lane_vec_t o_rd_weight
);

	lane_vec_t data_mem   [DEPTH];
	lane_vec_t weight_mem [DEPTH];

	// write side, sel picks the bank
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			if (i_wr_sel)
				weight_mem[i_wr_addr] <= i_wr_data;
			else
				data_mem[i_wr_addr] <= i_wr_data;
		end
	end

	// both banks read together, independent addresses
	always_ff @(posedge clk) begin
		if (i_rd_en) begin
			o_rd_data   <= data_mem[i_rd_daddr];
			o_rd_weight <= weight_mem[i_rd_waddr]; // pool reads ignore this one
		end
	end

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter import engine_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	// conv side
	input  logic  i_conv_req,
	input  addr_t i_conv_daddr,
	input  addr_t i_conv_waddr,
	// pool side
	input  logic  i_pool_req,
	input  addr_t i_pool_daddr,
	// grants and return strobes
	output logic  o_conv_gnt,
	output logic  o_pool_gnt,
	output logic  o_conv_rvalid,
	output logic  o_pool_rvalid,
	// to operand_mem
	output logic  o_rd_en,
	output addr_t o_rd_daddr,
	output addr_t o_rd_waddr
);

	logic last_conv; // conv won the previous grant

	// conv wins unless pool is waiting and conv had the last turn
	assign o_conv_gnt = i_conv_req & (~i_pool_req | ~last_conv);
	assign o_pool_gnt = i_pool_req & ~o_conv_gnt;

	assign o_rd_en    = o_conv_gnt | o_pool_gnt;
	assign o_rd_daddr = o_pool_gnt ? i_pool_daddr : i_conv_daddr;
	assign o_rd_waddr = i_conv_waddr; // pool has no weight read

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_conv <= 1'b0;
		end else if (o_conv_gnt) begin
			last_conv <= 1'b1;
		end else if (o_pool_gnt) begin
			last_conv <= 1'b0;
		end
	end

	// memory answers one cycle after the grant
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_conv_rvalid <= 1'b0;
			o_pool_rvalid <= 1'b0;
		end else begin
			o_conv_rvalid <= o_conv_gnt;
			o_pool_rvalid <= o_pool_gnt;
		end
	end

endmodule

// File: hw/conv_unit.sv
`timescale 1ns/100ps

module conv_unit import engine_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	// window command
	input  logic               i_start,
	input  addr_t              i_daddr,
	input  addr_t              i_waddr,
	input  logic [KLOG2_W-1:0] i_klog2,
	input  word_t              i_bias,
	// arbiter
	input  logic               i_gnt,
	input  logic               i_rvalid,
	input  lane_vec_t          i_rd_data,
	input  lane_vec_t          i_rd_weight,
	output logic               o_req,
	output addr_t              o_daddr,
	output addr_t              o_waddr,
	// result
	output logic               o_busy,
	output logic               o_valid,
	output word_t              o_result
);

	logic  accept;
	cnt_t  win_len;
	cnt_t  issue_left; // grants still to collect
	cnt_t  recv_left;  // words still to come back
	logic  fin;        // acc holds the full window
	word_t bias_q;
	acc_t  acc;
	acc_t  lane_sum;
	acc_t  biased;
	word_t relu_sat;

	assign accept  = i_start & ~o_busy;
	assign win_len = cnt_t'(1) << i_klog2;

	// dot product of one word pair across all lanes
	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < LANES; i++) begin
			lane_sum = lane_sum +
				acc_t'(word_t'(i_rd_data[i])) * acc_t'(word_t'(i_rd_weight[i]));
		end
	end

	// bias, relu, clamp to positive word range
	always_comb begin
		biased = acc + acc_t'(bias_q);
		if (biased < 0)
			relu_sat = '0;
		else if (biased > acc_t'(SAT_MAX))
			relu_sat = SAT_MAX;
		else
			relu_sat = word_t'(biased);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_busy     <= 1'b0;
			o_req      <= 1'b0;
			o_valid    <= 1'b0;
			fin        <= 1'b0;
			issue_left <= '0;
			recv_left  <= '0;
		end else begin
			o_valid <= 1'b0;
			if (accept) begin
				o_busy     <= 1'b1;
				o_req      <= 1'b1;
				issue_left <= win_len;
				recv_left  <= win_len;
			end
			// issue side
			if (o_req && i_gnt) begin
				issue_left <= issue_left - 1'b1;
				if (issue_left == cnt_t'(1))
					o_req <= 1'b0; // last address granted
			end
			// receive side
			if (i_rvalid) begin
				recv_left <= recv_left - 1'b1;
				if (recv_left == cnt_t'(1))
					fin <= 1'b1;
			end
			if (fin) begin
				fin     <= 1'b0;
				o_busy  <= 1'b0;
				o_valid <= 1'b1;
			end
		end
	end

	// addresses, accumulator and result
	always_ff @(posedge clk) begin
		if (accept) begin
			o_daddr <= i_daddr;
			o_waddr <= i_waddr;
			bias_q  <= i_bias;
			acc     <= '0;
		end
		if (o_req && i_gnt) begin
			o_daddr <= o_daddr + 1'b1;
			o_waddr <= o_waddr + 1'b1;
		end
		if (i_rvalid)
			acc <= acc + lane_sum;
		if (fin)
			o_result <= relu_sat;
	end

endmodule

// File: hw/pool_unit.sv
`timescale 1ns/100ps

module pool_unit import engine_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	// window command
	input  logic               i_start,
	input  addr_t              i_daddr,
	input  logic [KLOG2_W-1:0] i_klog2,
	input  pool_op_t           i_op,
	// arbiter
	input  logic               i_gnt,
	input  logic               i_rvalid,
	input  lane_vec_t          i_rd_data,
	output logic               o_req,
	output addr_t              o_daddr,
	// result
	output logic               o_busy,
	output logic               o_valid,
	output lane_vec_t          o_result
);

	logic               accept;
	cnt_t               win_len;
	cnt_t               issue_left;
	cnt_t               recv_left;
	logic               first; // next returned word opens the window
	logic               fin;
	logic [KLOG2_W-1:0] klog2_q;
	pool_op_t           op_q;
	acc_t               lane_acc  [LANES]; // running max or running sum
	acc_t               lane_next [LANES];
	lane_vec_t          pooled;

	assign accept  = i_start & ~o_busy;
	assign win_len = cnt_t'(1) << i_klog2;

	// per-lane update on each returned word
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			if (first)
				lane_next[i] = acc_t'(word_t'(i_rd_data[i]));
			else if (op_q == POOL_MAX)
				lane_next[i] = (acc_t'(word_t'(i_rd_data[i])) > lane_acc[i]) ?
					acc_t'(word_t'(i_rd_data[i])) : lane_acc[i];
			else
				lane_next[i] = lane_acc[i] + acc_t'(word_t'(i_rd_data[i]));
		end
	end

	// average is an arithmetic shift, max passes through
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			if (op_q == POOL_AVG)
				pooled[i] = word_t'(lane_acc[i] >>> klog2_q);
			else
				pooled[i] = word_t'(lane_acc[i]);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_busy     <= 1'b0;
			o_req      <= 1'b0;
			o_valid    <= 1'b0;
			fin        <= 1'b0;
			first      <= 1'b0;
			issue_left <= '0;
			recv_left  <= '0;
		end else begin
			o_valid <= 1'b0;
			if (accept) begin
				o_busy     <= 1'b1;
				o_req      <= 1'b1;
				first      <= 1'b1;
				issue_left <= win_len;
				recv_left  <= win_len;
			end
			if (o_req && i_gnt) begin
				issue_left <= issue_left - 1'b1;
				if (issue_left == cnt_t'(1))
					o_req <= 1'b0;
			end
			if (i_rvalid) begin
				first     <= 1'b0;
				recv_left <= recv_left - 1'b1;
				if (recv_left == cnt_t'(1))
					fin <= 1'b1; // window complete
			end
			if (fin) begin
				fin     <= 1'b0;
				o_busy  <= 1'b0;
				o_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_daddr <= i_daddr;
			klog2_q <= i_klog2;
			op_q    <= i_op;
		end
		if (o_req && i_gnt)
			o_daddr <= o_daddr + 1'b1;
		if (i_rvalid)
			lane_acc <= lane_next;
		if (fin)
			o_result <= pooled;
	end

endmodule

// File: hw/engine_top.sv
`timescale 1ns/100ps

module engine_top import engine_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	// memory load
	input  logic               i_wr_en,
	input  logic               i_wr_sel,
	input  addr_t              i_wr_addr,
	input  lane_vec_t          i_wr_data,
	// convolution command
	input  logic               i_conv_start,
	input  addr_t              i_conv_daddr,
	input  addr_t              i_conv_waddr,
	input  logic [KLOG2_W-1:0] i_conv_klog2,
	input  word_t              i_conv_bias,
	// pooling command
	input  logic               i_pool_start,
	input  addr_t              i_pool_daddr,
	input  logic [KLOG2_W-1:0] i_pool_klog2,
	input  pool_op_t           i_pool_op,
	// results
	output logic               o_conv_busy,
	output logic               o_conv_valid,
	output word_t              o_conv_result,
	output logic               o_pool_busy,
	output logic               o_pool_valid,
	output lane_vec_t          o_pool_result
);

	logic      conv_req, conv_gnt, conv_rvalid;
	logic      pool_req, pool_gnt, pool_rvalid;
	addr_t     conv_daddr, conv_waddr, pool_daddr;
	logic      rd_en;
	addr_t     rd_daddr, rd_waddr;
	lane_vec_t rd_data, rd_weight; // shared return buses

	operand_mem operand_mem_inst (
		.clk         (clk),
		.i_wr_en     (i_wr_en),
		.i_wr_sel    (i_wr_sel),
		.i_wr_addr   (i_wr_addr),
		.i_wr_data   (i_wr_data),
		.i_rd_en     (rd_en),
		.i_rd_daddr  (rd_daddr),
		.i_rd_waddr  (rd_waddr),
		.o_rd_data   (rd_data),
		.o_rd_weight (rd_weight)
	);

	mem_arbiter mem_arbiter_inst (
		.clk           (clk),
		.rst           (rst),
		.i_conv_req    (conv_req),
		.i_conv_daddr  (conv_daddr),
		.i_conv_waddr  (conv_waddr),
		.i_pool_req    (pool_req),
		.i_pool_daddr  (pool_daddr),
		.o_conv_gnt    (conv_gnt),
		.o_pool_gnt    (pool_gnt),
		.o_conv_rvalid (conv_rvalid),
		.o_pool_rvalid (pool_rvalid),
		.o_rd_en       (rd_en),
		.o_rd_daddr    (rd_daddr),
		.o_rd_waddr    (rd_waddr)
	);

	conv_unit conv_unit_inst (
		.clk         (clk),
		.rst         (rst),
		.i_start     (i_conv_start),
		.i_daddr     (i_conv_daddr),
		.i_waddr     (i_conv_waddr),
		.i_klog2     (i_conv_klog2),
		.i_bias      (i_conv_bias),
		.i_gnt       (conv_gnt),
		.i_rvalid    (conv_rvalid),
		.i_rd_data   (rd_data),
		.i_rd_weight (rd_weight),
		.o_req       (conv_req),
		.o_daddr     (conv_daddr),
		.o_waddr     (conv_waddr),
		.o_busy      (o_conv_busy),
		.o_valid     (o_conv_valid),
		.o_result    (o_conv_result)
	);

	pool_unit pool_unit_inst (
		.clk       (clk),
		.rst       (rst),
		.i_start   (i_pool_start),
		.i_daddr   (i_pool_daddr),
		.i_klog2   (i_pool_klog2),
		.i_op      (i_pool_op),
		.i_gnt     (pool_gnt),
		.i_rvalid  (pool_rvalid),
		.i_rd_data (rd_data),
		.o_req     (pool_req),
		.o_daddr   (pool_daddr),
		.o_busy    (o_pool_busy),
		.o_valid   (o_pool_valid),
		.o_result  (o_pool_result)
	);

endmodule

// File: test/engine_top_assert.sv
`timescale 1ns/100ps

module engine_top_assert import engine_pkg::*; (
	input logic clk,
	input logic rst,
	input logic conv_req,
	input logic pool_req,
	input logic conv_gnt,
	input logic pool_gnt,
	input logic conv_rvalid,
	input logic pool_rvalid,
	input logic conv_valid,
	input logic pool_valid
);

	int fail_cnt = 0; // failed assertions so far

	// arbiter never grants both units
	gnt_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({conv_gnt, pool_gnt}))
		else begin
			$error("conv and pool granted in the same cycle");
			fail_cnt++;
		end

	conv_gnt_req: assert property (@(posedge clk) disable iff (rst) conv_gnt |-> conv_req)
		else begin
			$error("conv grant without request");
			fail_cnt++;
		end

	pool_gnt_req: assert property (@(posedge clk) disable iff (rst) pool_gnt |-> pool_req)
		else begin
			$error("pool grant without request");
			fail_cnt++;
		end

	// read return trails the grant by one cycle
	conv_rvalid_lag: assert property (@(posedge clk) disable iff (rst)
		conv_rvalid == $past(conv_gnt))
		else begin
			$error("conv rvalid not one cycle after grant");
			fail_cnt++;
		end

	pool_rvalid_lag: assert property (@(posedge clk) disable iff (rst)
		pool_rvalid == $past(pool_gnt))
		else begin
			$error("pool rvalid not one cycle after grant");
			fail_cnt++;
		end

	conv_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		conv_valid |=> !conv_valid)
		else begin
			$error("conv valid held longer than one cycle");
			fail_cnt++;
		end

	pool_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		pool_valid |=> !pool_valid)
		else begin
			$error("pool valid held longer than one cycle");
			fail_cnt++;
		end

endmodule

bind engine_top engine_top_assert engine_top_assert_inst (
	.clk         (clk),
	.rst         (rst),
	.conv_req    (conv_req),
	.pool_req    (pool_req),
	.conv_gnt    (conv_gnt),
	.pool_gnt    (pool_gnt),
	.conv_rvalid (conv_rvalid),
	.pool_rvalid (pool_rvalid),
	.conv_valid  (o_conv_valid),
	.pool_valid  (o_pool_valid)
);

// File: test/engine_top_tb.sv
`timescale 1ns/100ps

module engine_top_tb import engine_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DLY    = 10;
	localparam int RST_CYCLES   = 4;
	localparam int SETTLE       = 4; // idle cycles to catch a stray second valid
	localparam int NUM_ENTRIES  = 17;
	localparam int ENTRY_CYCLES = 2 * 8 + 10; // two longest windows plus overhead
	localparam int WATCHDOG_CYCLES =
		RST_CYCLES + 2 * DEPTH + NUM_ENTRIES * ENTRY_CYCLES + 20;

	typedef struct packed {
		logic               run_conv;
		logic               run_pool;
		logic               restart; // second start while busy
		addr_t              c_daddr;
		addr_t              c_waddr;
		logic [KLOG2_W-1:0] c_klog2;
		word_t              c_bias;
		addr_t              p_daddr;
		logic [KLOG2_W-1:0] p_klog2;
		pool_op_t           p_op;
		word_t              exp_conv;
		lane_vec_t          exp_pool;
	} entry_t;

	logic               clk, rst;
	logic               i_wr_en, i_wr_sel;
	addr_t              i_wr_addr;
	lane_vec_t          i_wr_data;
	logic               i_conv_start, i_pool_start;
	addr_t              i_conv_daddr, i_conv_waddr, i_pool_daddr;
	logic [KLOG2_W-1:0] i_conv_klog2, i_pool_klog2;
	word_t              i_conv_bias;
	pool_op_t           i_pool_op;
	logic               o_conv_busy, o_conv_valid, o_pool_busy, o_pool_valid;
	word_t              o_conv_result;
	lane_vec_t          o_pool_result;

	lane_vec_t data_copy   [DEPTH];
	lane_vec_t weight_copy [DEPTH];
	entry_t    tbl [NUM_ENTRIES];
	int        seed = 76;
	int        cyc = 0;
	int        conv_seen, pool_seen, conv_cyc, pool_cyc;
	word_t     conv_got;
	lane_vec_t pool_got;

	engine_top engine_top_inst (
		.clk           (clk),
		.rst           (rst),
		.i_wr_en       (i_wr_en),
		.i_wr_sel      (i_wr_sel),
		.i_wr_addr     (i_wr_addr),
		.i_wr_data     (i_wr_data),
		.i_conv_start  (i_conv_start),
		.i_conv_daddr  (i_conv_daddr),
		.i_conv_waddr  (i_conv_waddr),
		.i_conv_klog2  (i_conv_klog2),
		.i_conv_bias   (i_conv_bias),
		.i_pool_start  (i_pool_start),
		.i_pool_daddr  (i_pool_daddr),
		.i_pool_klog2  (i_pool_klog2),
		.i_pool_op     (i_pool_op),
		.o_conv_busy   (o_conv_busy),
		.o_conv_valid  (o_conv_valid),
		.o_conv_result (o_conv_result),
		.o_pool_busy   (o_pool_busy),
		.o_pool_valid  (o_pool_valid),
		.o_pool_result (o_pool_result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// results are only there during the pulse, grab them mid-cycle
	always @(negedge clk) begin
		if (o_conv_valid) begin
			conv_seen++;
			conv_got = o_conv_result;
			conv_cyc = cyc;
		end
		if (o_pool_valid) begin
			pool_seen++;
			pool_got = o_pool_result;
			pool_cyc = cyc;
		end
	end

	// stop on the first failed assertion
	always @(negedge clk) begin
		if (engine_top_inst.engine_top_assert_inst.fail_cnt != 0)
			fail_run("an assertion in engine_top_assert failed");
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, no result arrived", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp)
			fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_lanes(string name, lane_vec_t got, lane_vec_t exp);
		for (int l = 0; l < LANES; l++)
			check_word($sformatf("%s[%0d]", name, l), got[l], exp[l]);
	endtask

	// random words in +-300, two fixed-sign regions at the top
	task automatic preload();
		lane_vec_t w;
		int        v;
		for (int sel = 0; sel < 2; sel++) begin
			for (int a = 0; a < DEPTH; a++) begin
				for (int l = 0; l < LANES; l++) begin
					v = $random(seed) % 301;
					if (a >= 48 && (sel == 1 || a < 56) && v < 0)
						v = -v; // positive region
					else if (a >= 56 && sel == 0 && v >= 0)
						v = -v - 1; // all-negative data
					w[l] = word_t'(v);
				end
				if (sel == 0)
					data_copy[a] = w;
				else
					weight_copy[a] = w;
				@(posedge clk);
				#DRIVE_DLY;
				i_wr_en   = 1'b1;
				i_wr_sel  = (sel == 1);
				i_wr_addr = addr_t'(a);
				i_wr_data = w;
			end
		end
		@(posedge clk);
		#DRIVE_DLY;
		i_wr_en = 1'b0;
	endtask

	function automatic entry_t make_entry(logic rc, logic rp, logic rs, int cd, int cw,
		int ck, int cb, int pd, int pk, pool_op_t op);
		entry_t e;
		e          = '0;
		e.run_conv = rc;
		e.run_pool = rp;
		e.restart  = rs;
		e.c_daddr  = addr_t'(cd);
		e.c_waddr  = addr_t'(cw);
		e.c_klog2  = ck[KLOG2_W-1:0];
		e.c_bias   = word_t'(cb);
		e.p_daddr  = addr_t'(pd);
		e.p_klog2  = pk[KLOG2_W-1:0];
		e.p_op     = op;
		return e;
	endfunction

	// relu of dot product plus bias, clamped to 32767
	function automatic word_t ref_conv(entry_t e);
		longint sum;
		addr_t  da, wa;
		sum = e.c_bias;
		da  = e.c_daddr;
		wa  = e.c_waddr;
		for (int k = 0; k < (1 << e.c_klog2); k++) begin
			for (int l = 0; l < LANES; l++)
				sum += longint'(data_copy[da][l]) * longint'(weight_copy[wa][l]);
			da++;
			wa++;
		end
		if (sum < 0)
			return '0;
		if (sum > 32767)
			return word_t'(32767);
		return word_t'(sum);
	endfunction

	function automatic lane_vec_t ref_pool(entry_t e);
		lane_vec_t r;
		longint    best, sum;
		addr_t     a;
		for (int l = 0; l < LANES; l++) begin
			a    = e.p_daddr;
			best = data_copy[a][l];
			sum  = 0;
			for (int k = 0; k < (1 << e.p_klog2); k++) begin
				if (data_copy[a][l] > best)
					best = data_copy[a][l];
				sum += data_copy[a][l];
				a++;
			end
			r[l] = (e.p_op == POOL_MAX) ? word_t'(best) : word_t'(sum >>> e.p_klog2);
		end
		return r;
	endfunction

	task automatic run_entry(int idx, entry_t e);
		int n_c, n_p, start_cyc, lat;
		n_c = 1 << e.c_klog2;
		n_p = 1 << e.p_klog2;
		@(posedge clk);
		#DRIVE_DLY;
		conv_seen    = 0;
		pool_seen    = 0;
		i_conv_start = e.run_conv;
		i_conv_daddr = e.c_daddr;
		i_conv_waddr = e.c_waddr;
		i_conv_klog2 = e.c_klog2;
		i_conv_bias  = e.c_bias;
		i_pool_start = e.run_pool;
		i_pool_daddr = e.p_daddr;
		i_pool_klog2 = e.p_klog2;
		i_pool_op    = e.p_op;
		start_cyc    = cyc;
		@(posedge clk);
		#DRIVE_DLY;
		i_conv_start = 1'b0;
		i_pool_start = 1'b0;
		if (e.restart) begin
			@(posedge clk);
			#DRIVE_DLY;
			i_conv_start = e.run_conv; // units are busy, these must be dropped
			i_pool_start = e.run_pool;
			i_conv_daddr = e.c_daddr + 8;
			i_conv_klog2 = ~e.c_klog2;
			i_conv_bias  = e.c_bias + 1;
			i_pool_daddr = e.p_daddr + 8;
			i_pool_op    = (e.p_op == POOL_MAX) ? POOL_AVG : POOL_MAX;
			@(posedge clk);
			#DRIVE_DLY;
			i_conv_start = 1'b0;
			i_pool_start = 1'b0;
		end
		while ((e.run_conv && conv_seen == 0) || (e.run_pool && pool_seen == 0))
			@(negedge clk);
		repeat (SETTLE) @(negedge clk);
		check_count($sformatf("entry %0d conv valid count", idx), conv_seen, e.run_conv);
		check_count($sformatf("entry %0d pool valid count", idx), pool_seen, e.run_pool);
		if (e.run_conv) begin
			check_word("o_conv_result", conv_got, e.exp_conv);
			lat = conv_cyc - start_cyc;
			if (!e.run_pool)
				check_count("conv latency", lat, n_c + 3);
			else if (lat > n_c + n_p + 3)
				fail_run($sformatf("conv result took %0d cycles under contention", lat));
		end
		if (e.run_pool) begin
			check_lanes("o_pool_result", pool_got, e.exp_pool);
			lat = pool_cyc - start_cyc;
			if (!e.run_conv)
				check_count("pool latency", lat, n_p + 3);
			else if (lat > n_c + n_p + 3)
				fail_run($sformatf("pool result took %0d cycles under contention", lat));
		end
		check_bit("o_conv_busy", o_conv_busy, 1'b0);
		check_bit("o_pool_busy", o_pool_busy, 1'b0);
	endtask

	initial begin
		rst          = 1'b1;
		i_wr_en      = 1'b0;
		i_wr_sel     = 1'b0;
		i_wr_addr    = '0;
		i_wr_data    = '0;
		i_conv_start = 1'b0;
		i_conv_daddr = '0;
		i_conv_waddr = '0;
		i_conv_klog2 = '0;
		i_conv_bias  = '0;
		i_pool_start = 1'b0;
		i_pool_daddr = '0;
		i_pool_klog2 = '0;
		i_pool_op    = POOL_MAX;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		check_bit("o_conv_busy", o_conv_busy, 1'b0);
		check_bit("o_conv_valid", o_conv_valid, 1'b0);
		check_bit("o_pool_busy", o_pool_busy, 1'b0);
		check_bit("o_pool_valid", o_pool_valid, 1'b0);
		preload();

		//                  conv pool rst c_da c_wa c_k bias    p_da p_k op
		tbl[0]  = make_entry(1, 0, 0,  0,  0, 0,   100,  0, 0, POOL_MAX);
		tbl[1]  = make_entry(1, 0, 0,  4, 10, 1,   -50,  0, 0, POOL_MAX);
		tbl[2]  = make_entry(1, 0, 0,  8, 20, 2,     0,  0, 0, POOL_MAX);
		tbl[3]  = make_entry(1, 0, 0, 16, 30, 3,  1000,  0, 0, POOL_MAX);
		tbl[4]  = make_entry(1, 0, 0, 56, 56, 3,     0,  0, 0, POOL_MAX); // relu to 0
		tbl[5]  = make_entry(1, 0, 0, 48, 48, 3, 32767,  0, 0, POOL_MAX); // saturates
		tbl[6]  = make_entry(0, 1, 0,  0,  0, 0,     0,  0, 0, POOL_MAX);
		tbl[7]  = make_entry(0, 1, 0,  0,  0, 0,     0, 12, 2, POOL_MAX);
		tbl[8]  = make_entry(0, 1, 0,  0,  0, 0,     0, 56, 3, POOL_MAX); // all negative
		tbl[9]  = make_entry(0, 1, 0,  0,  0, 0,     0, 24, 1, POOL_AVG);
		tbl[10] = make_entry(0, 1, 0,  0,  0, 0,     0, 32, 3, POOL_AVG);
		tbl[11] = make_entry(0, 1, 0,  0,  0, 0,     0, 57, 2, POOL_AVG);
		tbl[12] = make_entry(1, 1, 0, 40,  2, 2,     5, 20, 2, POOL_MAX);
		tbl[13] = make_entry(1, 1, 0,  1, 40, 3,  -300,  8, 3, POOL_AVG);
		tbl[14] = make_entry(1, 1, 0,  3,  3, 0,     0,  5, 0, POOL_MAX);
		tbl[15] = make_entry(1, 0, 1,  6, 14, 2,     7,  0, 0, POOL_MAX);
		tbl[16] = make_entry(0, 1, 1,  0,  0, 0,     0, 30, 1, POOL_AVG);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			tbl[i].exp_conv = ref_conv(tbl[i]);
			tbl[i].exp_pool = ref_pool(tbl[i]);
		end

		for (int i = 0; i < NUM_ENTRIES; i++)
			run_entry(i, tbl[i]);

		if (engine_top_inst.engine_top_assert_inst.fail_cnt == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("%0d assertion failures during the run",
				engine_top_inst.engine_top_assert_inst.fail_cnt);
			$display("TEST FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// File: engine_top.f
hw/engine_pkg.sv
hw/operand_mem.sv
hw/mem_arbiter.sv
hw/conv_unit.sv
hw/pool_unit.sv
hw/engine_top.sv
test/engine_top_assert.sv
test/engine_top_tb.sv

// File: Bender.yml
package:
  name: engine_top

sources:
  - files:
      - hw/engine_pkg.sv
      - hw/operand_mem.sv
      - hw/mem_arbiter.sv
      - hw/conv_unit.sv
      - hw/pool_unit.sv
      - hw/engine_top.sv
  - target: test
    files:
      - test/engine_top_assert.sv
      - test/engine_top_tb.sv
